// ==== Bender.yml ====
package:
  name: udp_transmit_handler

sources:
  - udp_proto_pkg.sv
  - udp_tx_ctrl_pkg.sv
  - udp_header_if.sv
  - udp_header_decoder.sv
  - udp_payload_checksum.sv
  - udp_fragment_sequencer.sv
  - udp_transmit_handler.sv
  - target: test
    files:
      - tb_udp_transmit_handler.sv

// ==== sources.f ====
udp_proto_pkg.sv
udp_tx_ctrl_pkg.sv
udp_header_if.sv
udp_header_decoder.sv
udp_payload_checksum.sv
udp_fragment_sequencer.sv
udp_transmit_handler.sv
tb_udp_transmit_handler.sv

// ==== tb_udp_transmit_handler.sv ====
module tb_udp_transmit_handler;

    typedef struct packed {
        udp_proto_pkg::mac_addr_t  mac;
        udp_proto_pkg::ipv4_addr_t dst;
        udp_proto_pkg::ipv4_addr_t src;
        udp_proto_pkg::udp_port_t  sport;
        udp_proto_pkg::udp_port_t  dport;
        udp_proto_pkg::word16_t    size;
        logic [7:0]                garbage;
        logic [7:0]                busy;
    } frame_t;

    localparam int          TIMEOUT  = 20000;
    localparam int          FRAMES   = 4;
    localparam logic [15:0] MAX_FRAG = 16'd1472;

    logic                      clock, reset_n, enable, data_enable;
    logic [8:0]                data;
    udp_proto_pkg::ipv4_addr_t ipv4_source;
    logic                      data_ready, udp_buffer_data_valid, transmit_valid;
    udp_proto_pkg::mac_addr_t  mac_destination;
    udp_proto_pkg::ipv4_addr_t ipv4_destination;
    udp_proto_pkg::udp_port_t  udp_source, udp_destination;
    udp_proto_pkg::word16_t    udp_total_payload_size, udp_buffer_write_address;
    udp_proto_pkg::byte_t      udp_buffer_data;
    udp_proto_pkg::word16_t    udp_checksum, udp_fragment_size;
    udp_proto_pkg::word16_t    ipv4_flags, ipv4_identification;

    frame_t                 frames [0:FRAMES-1];
    udp_proto_pkg::byte_t   payload [0:4095];
    udp_proto_pkg::word16_t wr_addr_q[$], tx_size_q[$], tx_flags_q[$], tx_sum_q[$], tx_id_q[$];
    udp_proto_pkg::byte_t   wr_data_q[$];
    logic [31:0]            rng_state;
    int                     busy_cycles, error_count, frames_run;
    int                     handshakes_done = 0;
    logic                   timeout_hit;

    udp_transmit_handler #(.max_fragment_bytes(MAX_FRAG)) dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Transmitter stays busy for a while after each fragment
    initial begin
        enable = 1'b1;
        forever begin
            @(negedge clock);
            if (transmit_valid) begin
                enable = 1'b0;
                repeat (busy_cycles) @(negedge clock);
                enable = 1'b1;
                handshakes_done <= handshakes_done + 1;
            end
        end
    end

    always @(negedge clock) begin
        if (reset_n && udp_buffer_data_valid) begin
            wr_addr_q.push_back(udp_buffer_write_address);
            wr_data_q.push_back(udp_buffer_data);
        end
        if (reset_n && transmit_valid) begin
            tx_size_q.push_back(udp_fragment_size);
            tx_flags_q.push_back(ipv4_flags);
            tx_sum_q.push_back(udp_checksum);
            tx_id_q.push_back(ipv4_identification);
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic compare_mac(input string name, input udp_proto_pkg::mac_addr_t got,
                               input udp_proto_pkg::mac_addr_t expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_ipv4(input string name, input udp_proto_pkg::ipv4_addr_t got,
                                input udp_proto_pkg::ipv4_addr_t expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_port(input string name, input udp_proto_pkg::udp_port_t got,
                                input udp_proto_pkg::udp_port_t expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_word(input string name, input udp_proto_pkg::word16_t got,
                                input udp_proto_pkg::word16_t expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_byte(input string name, input udp_proto_pkg::byte_t got,
                                input udp_proto_pkg::byte_t expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic udp_proto_pkg::word16_t expected_checksum(input frame_t fr);
        logic [31:0]            sum;
        udp_proto_pkg::word16_t length;
        udp_proto_pkg::word16_t result;
        sum    = 32'd0;
        length = fr.size + 16'd8;
        sum    = fr.src[31:16] + fr.src[15:0] + fr.dst[31:16] + fr.dst[15:0] + 32'd17
               + length + fr.sport + fr.dport + length;
        for (int k = 0; k < fr.size; k += 2) begin
            sum += {16'd0, payload[k], ((k + 1 < fr.size) ? payload[k + 1] : 8'h00)};
        end
        while (sum[31:16] != 16'd0) begin
            sum = sum[15:0] + sum[31:16];
        end
        result = ~sum[15:0];
        return (result == 16'h0000) ? 16'hffff : result;
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic send_byte(input logic [8:0] value);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!data_ready && waited < TIMEOUT) begin
            data_enable = 1'b0;
            @(negedge clock);
            waited++;
        end
        if (!data_ready) begin
            $display("Timeout: data_ready stayed low while a byte was waiting");
            timeout_hit = 1'b1;
        end else begin
            data        = value;
            data_enable = 1'b1;
        end
    endtask

    // Data_ready must stay low until the transmitter has finished the last fragment
    task automatic wait_frame_end(input int handshakes_expected);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < TIMEOUT) begin
            @(negedge clock);
            data_enable = 1'b0;
            if (data_ready && handshakes_done < handshakes_expected) begin
                $display("FAIL data_ready got %h expected %h", data_ready, 1'b0);
                error_count++;
            end
            done = data_ready && (handshakes_done >= handshakes_expected);
            waited++;
        end
        if (!done) begin
            $display("Timeout: frame did not finish, %0d fragments seen", tx_size_q.size());
            timeout_hit = 1'b1;
        end
    endtask

    task automatic run_frame(input int f);
        frame_t                 fr;
        logic [127:0]           hdr_bytes;
        int                     n_frag, remaining, offset, errors_before;
        int                     handshakes_expected;
        udp_proto_pkg::word16_t exp_flags;
        fr                  = frames[f];
        errors_before       = error_count;
        n_frag              = (fr.size + MAX_FRAG - 1) / MAX_FRAG;
        handshakes_expected = handshakes_done + n_frag;
        wr_addr_q.delete();
        wr_data_q.delete();
        tx_size_q.delete();
        tx_flags_q.delete();
        tx_sum_q.delete();
        tx_id_q.delete();
        for (int k = 0; k < fr.size; k++) begin
            rng_state  = xorshift(rng_state);
            payload[k] = rng_state[7:0];
        end
        ipv4_source = fr.src;
        busy_cycles = fr.busy;
        for (int k = 0; k < fr.garbage; k++) begin
            rng_state = xorshift(rng_state);
            send_byte({1'b0, rng_state[7:0]});
            if (timeout_hit) return;
        end
        hdr_bytes = {fr.mac, fr.dst, fr.sport, fr.dport, fr.size};
        for (int k = 0; k < 16; k++) begin
            send_byte({k == 0, hdr_bytes[127 - 8 * k -: 8]});
            if (timeout_hit) return;
        end
        for (int k = 0; k < fr.size; k++) begin
            send_byte({1'b0, payload[k]});
            if (timeout_hit) return;
        end
        wait_frame_end(handshakes_expected);
        if (timeout_hit) return;

        compare_mac("mac_destination", mac_destination, fr.mac);
        compare_ipv4("ipv4_destination", ipv4_destination, fr.dst);
        compare_port("udp_source", udp_source, fr.sport);
        compare_port("udp_destination", udp_destination, fr.dport);
        compare_word("udp_total_payload_size", udp_total_payload_size, fr.size);

        if (wr_addr_q.size() != fr.size) begin
            $display("Frame %0d wrote %0d buffer bytes instead of %0d", f, wr_addr_q.size(),
                     fr.size);
            error_count++;
        end else begin
            for (int k = 0; k < fr.size; k++) begin
                compare_word("udp_buffer_write_address", wr_addr_q[k], 16'(k));
                compare_byte("udp_buffer_data", wr_data_q[k], payload[k]);
            end
        end

        if (tx_size_q.size() != n_frag) begin
            $display("Frame %0d sent %0d fragments instead of %0d", f, tx_size_q.size(), n_frag);
            error_count++;
        end else begin
            compare_word("udp_checksum", tx_sum_q[0], expected_checksum(fr));
            remaining = fr.size;
            offset    = 0;
            for (int k = 0; k < n_frag; k++) begin
                exp_flags = 16'(offset);
                if (remaining > MAX_FRAG) begin
                    exp_flags[udp_proto_pkg::FLAG_MORE_FRAGMENTS] = 1'b1;
                end
                compare_word("udp_fragment_size", tx_size_q[k],
                             16'((remaining < MAX_FRAG) ? remaining : MAX_FRAG));
                compare_word("ipv4_flags", tx_flags_q[k], exp_flags);
                compare_word("ipv4_identification", tx_id_q[k], 16'(f));
                remaining -= MAX_FRAG;
                offset    += MAX_FRAG / 8;
            end
        end
        compare_word("ipv4_identification", ipv4_identification, 16'(f + 1));
        frames_run++;
        $display("Frame %0d size %0d fragments %0d: %s", f, fr.size, n_frag,
                 (error_count == errors_before) ? "pass" : "fail");
    endtask

    initial begin
        reset_n     = 1'b0;
        data        = '0;
        data_enable = 1'b0;
        ipv4_source = '0;
        rng_state   = 32'hfc6;
        busy_cycles = 1;
        error_count = 0;
        frames_run  = 0;
        timeout_hit = 1'b0;
        // mac, destination, source, ports, size, garbage bytes, busy cycles
        frames[0] = {48'h02005e102030, 32'hc0a80a01, 32'hc0a80a02, 16'd5000, 16'd53,
                     16'd5, 8'd3, 8'd2};
        frames[1] = {48'h0a1b2c3d4e5f, 32'h0a000001, 32'h0a0000fe, 16'd1234, 16'd4321,
                     16'd1472, 8'd0, 8'd5};
        frames[2] = {48'hffeeddccbbaa, 32'hac100005, 32'hac1000c8, 16'd68, 16'd67,
                     16'd1473, 8'd7, 8'd1};
        frames[3] = {48'h3c0ff00d1234, 32'he0000001, 32'hc0a80164, 16'd40000, 16'd9,
                     16'd3000, 8'd1, 8'd3};
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        compare_word("ipv4_identification", ipv4_identification, 16'd0);
        for (int f = 0; f < FRAMES && !timeout_hit; f++) begin
            run_frame(f);
        end
        $display("Frames run %0d of %0d, errors %0d", frames_run, FRAMES, error_count);
        if (timeout_hit || error_count != 0 || frames_run != FRAMES) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// ==== udp_fragment_sequencer.sv ====
module udp_fragment_sequencer #(
    parameter logic [15:0] max_fragment_bytes = 16'd1472
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   enable,
    udp_header_if.consumer         hdr,
    input  logic                   checksum_done,
    output udp_proto_pkg::word16_t udp_fragment_size,
    output udp_proto_pkg::word16_t ipv4_flags,
    output udp_proto_pkg::word16_t ipv4_identification,
    output logic                   transmit_valid,
    output logic                   frame_done
);

    localparam logic [12:0] OFFSET_STEP =
        13'(max_fragment_bytes / udp_proto_pkg::FRAGMENT_OFFSET_UNIT);

    udp_tx_ctrl_pkg::tx_state_e state;
    udp_proto_pkg::word16_t     bytes_left;
    udp_proto_pkg::word16_t     next_size;
    logic [12:0]                fragment_offset;
    logic                       more_fragments;

    assign next_size      = (bytes_left < max_fragment_bytes) ? bytes_left : max_fragment_bytes;
    assign more_fragments = (bytes_left != next_size);

    ////////////////////////////////////////
    // Fragment fields
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (state == udp_tx_ctrl_pkg::TX_PLAN) begin
            udp_fragment_size <= next_size;
            ipv4_flags        <= '0;
            ipv4_flags[udp_proto_pkg::FLAG_MORE_FRAGMENTS] <= more_fragments;
            ipv4_flags[12:0]  <= fragment_offset;
        end
    end

    ////////////////////////////////////////
    // Transmit FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state               <= udp_tx_ctrl_pkg::TX_IDLE;
            bytes_left          <= '0;
            fragment_offset     <= '0;
            ipv4_identification <= '0;
            transmit_valid      <= 1'b0;
            frame_done          <= 1'b0;
        end else begin
            transmit_valid <= 1'b0;
            frame_done     <= 1'b0;
            case (state)
                udp_tx_ctrl_pkg::TX_IDLE: begin
                    if (checksum_done) begin
                        bytes_left      <= hdr.payload_size;
                        fragment_offset <= '0;
                        state           <= udp_tx_ctrl_pkg::TX_PLAN;
                    end
                end
                udp_tx_ctrl_pkg::TX_PLAN: begin
                    bytes_left <= bytes_left - next_size;
                    state      <= udp_tx_ctrl_pkg::TX_OFFER;
                end
                udp_tx_ctrl_pkg::TX_OFFER: begin
                    if (enable) begin
                        transmit_valid <= 1'b1;
                        state          <= udp_tx_ctrl_pkg::TX_WAIT_BUSY;
                    end
                end
                udp_tx_ctrl_pkg::TX_WAIT_BUSY: begin
                    // Transmitter drops enable once it has taken the fragment
                    if (!enable) begin
                        state <= udp_tx_ctrl_pkg::TX_WAIT_DONE;
                    end
                end
                udp_tx_ctrl_pkg::TX_WAIT_DONE: begin
                    if (enable) begin
                        if (bytes_left == 16'd0) begin
                            ipv4_identification <= ipv4_identification + 16'd1;
                            frame_done          <= 1'b1;
                            state               <= udp_tx_ctrl_pkg::TX_IDLE;
                        end else begin
                            fragment_offset <= fragment_offset + OFFSET_STEP;
                            state           <= udp_tx_ctrl_pkg::TX_PLAN;
                        end
                    end
                end
                default: begin
                    state <= udp_tx_ctrl_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== udp_header_decoder.sv ====
module udp_header_decoder (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic [8:0]           data,
    input  logic                 data_enable,
    output logic                 data_ready,
    udp_header_if.decoder        hdr,
    output udp_proto_pkg::byte_t payload_byte,
    output logic                 payload_valid,
    output logic                 payload_last,
    input  logic                 frame_done
);

    udp_tx_ctrl_pkg::rx_state_e state;
    logic                       accept;
    logic [3:0]                 byte_count;
    logic [127:0]               header_shift;
    udp_proto_pkg::word16_t     bytes_left;

    assign accept = data_enable & data_ready;

    // Fields sit in stream order, first byte at the top
    assign hdr.mac_destination  = header_shift[127:80];
    assign hdr.ipv4_destination = header_shift[79:48];
    assign hdr.udp_source       = header_shift[47:32];
    assign hdr.udp_destination  = header_shift[31:16];
    assign hdr.payload_size     = header_shift[15:0];

    ////////////////////////////////////////
    // Payload forwarding
    ////////////////////////////////////////

    assign payload_byte  = data[7:0];
    assign payload_valid = accept && (state == udp_tx_ctrl_pkg::RX_PAYLOAD);
    assign payload_last  = payload_valid && (bytes_left == 16'd1);

    always_ff @(posedge clock) begin
        if (accept && (state == udp_tx_ctrl_pkg::RX_IDLE || state == udp_tx_ctrl_pkg::RX_HEADER)) begin
            if (state == udp_tx_ctrl_pkg::RX_HEADER || data[8]) begin
                header_shift <= {header_shift[119:0], data[7:0]};
            end
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state             <= udp_tx_ctrl_pkg::RX_IDLE;
            byte_count        <= '0;
            bytes_left        <= '0;
            hdr.header_valid  <= 1'b0;
            data_ready        <= 1'b0;
        end else begin
            hdr.header_valid <= 1'b0;
            data_ready       <= 1'b1;
            case (state)
                udp_tx_ctrl_pkg::RX_IDLE: begin
                    // Anything before the start marker is dropped
                    if (accept && data[8]) begin
                        byte_count <= 4'd1;
                        state      <= udp_tx_ctrl_pkg::RX_HEADER;
                    end
                end
                udp_tx_ctrl_pkg::RX_HEADER: begin
                    if (accept) begin
                        byte_count <= byte_count + 4'd1;
                        if (byte_count == 4'(udp_proto_pkg::HEADER_STREAM_BYTES - 1)) begin
                            bytes_left       <= {header_shift[7:0], data[7:0]};
                            hdr.header_valid <= 1'b1;
                            state            <= udp_tx_ctrl_pkg::RX_PAYLOAD;
                        end
                    end
                end
                udp_tx_ctrl_pkg::RX_PAYLOAD: begin
                    if (payload_valid) begin
                        bytes_left <= bytes_left - 16'd1;
                        if (payload_last) begin
                            data_ready <= 1'b0;
                            state      <= udp_tx_ctrl_pkg::RX_BUSY;
                        end
                    end
                end
                default: begin
                    // Hold off input until the last fragment is gone
                    if (frame_done) begin
                        state <= udp_tx_ctrl_pkg::RX_IDLE;
                    end else begin
                        data_ready <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== udp_header_if.sv ====
interface udp_header_if;

    udp_proto_pkg::mac_addr_t  mac_destination;
    udp_proto_pkg::ipv4_addr_t ipv4_destination;
    udp_proto_pkg::udp_port_t  udp_source;
    udp_proto_pkg::udp_port_t  udp_destination;
    udp_proto_pkg::word16_t    payload_size;
    logic                      header_valid;

    modport decoder (
        output mac_destination, ipv4_destination, udp_source,
        output udp_destination, payload_size, header_valid
    );

    // Fields hold until the next frame starts
    modport consumer (
        input mac_destination, ipv4_destination, udp_source,
        input udp_destination, payload_size, header_valid
    );

endinterface

// ==== udp_payload_checksum.sv ====
module udp_payload_checksum (
    input  logic                      clock,
    input  logic                      reset_n,
    input  udp_proto_pkg::ipv4_addr_t ipv4_source,
    udp_header_if.consumer            hdr,
    input  udp_proto_pkg::byte_t      payload_byte,
    input  logic                      payload_valid,
    input  logic                      payload_last,
    output udp_proto_pkg::word16_t    udp_buffer_write_address,
    output udp_proto_pkg::byte_t      udp_buffer_data,
    output logic                      udp_buffer_data_valid,
    output udp_proto_pkg::word16_t    udp_checksum,
    output logic                      checksum_done
);

    udp_proto_pkg::word16_t udp_length;
    logic [19:0]            pseudo_sum;
    logic [16:0]            pseudo_fold;
    logic [15:0]            pseudo_word;
    logic [16:0]            acc;
    logic [16:0]            acc_base;
    logic [16:0]            acc_sum;
    logic [15:0]            add_word;
    logic                   add_en;
    logic                   phase;
    udp_proto_pkg::byte_t   high_byte;
    udp_proto_pkg::word16_t write_count;
    logic                   fold_pending;
    logic [15:0]            folded;
    logic [15:0]            result;

    ////////////////////////////////////////
    // Pseudo header and UDP header
    ////////////////////////////////////////

    assign udp_length = hdr.payload_size + udp_proto_pkg::UDP_HEADER_BYTES;

    assign pseudo_sum = ipv4_source[31:16] + ipv4_source[15:0]
                      + hdr.ipv4_destination[31:16] + hdr.ipv4_destination[15:0]
                      + udp_proto_pkg::IPV4_PROTOCOL_UDP + udp_length
                      + hdr.udp_source + hdr.udp_destination + udp_length;

    // Two folds bring nine words back to 16 bits
    assign pseudo_fold = pseudo_sum[15:0] + pseudo_sum[19:16];
    assign pseudo_word = pseudo_fold[15:0] + pseudo_fold[16];

    // Carry is deferred to the next add, so 17 bits never overflow
    assign acc_base = hdr.header_valid ? {1'b0, pseudo_word} : acc;
    assign add_en   = payload_valid && (phase || payload_last);
    assign add_word = phase ? {high_byte, payload_byte} : {payload_byte, 8'h00};
    assign acc_sum  = {1'b0, acc_base[15:0]} + acc_base[16] + add_word;

    assign folded = acc[15:0] + acc[16];
    assign result = ~folded;

    always_ff @(posedge clock) begin
        acc             <= add_en ? acc_sum : acc_base;
        udp_buffer_data <= payload_byte;
        if (payload_valid) begin
            high_byte                <= payload_byte;
            udp_buffer_write_address <= write_count;
        end
        if (fold_pending) begin
            udp_checksum <= (result == 16'h0000) ? 16'hffff : result;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            phase                 <= 1'b0;
            write_count           <= '0;
            udp_buffer_data_valid <= 1'b0;
            fold_pending          <= 1'b0;
            checksum_done         <= 1'b0;
        end else begin
            udp_buffer_data_valid <= payload_valid;
            fold_pending          <= payload_valid && payload_last;
            checksum_done         <= fold_pending;
            if (payload_valid) begin
                // Start the next frame at address 0, high byte first
                phase       <= payload_last ? 1'b0 : ~phase;
                write_count <= payload_last ? 16'd0 : write_count + 16'd1;
            end
        end
    end

endmodule

// ==== udp_proto_pkg.sv ====
package udp_proto_pkg;

    // Field types
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] word16_t;
    typedef logic [7:0]  byte_t;

    ////////////////////////////////////////
    // IPv4
    ////////////////////////////////////////

    localparam byte_t IPV4_PROTOCOL_UDP = 8'h11;

    // Offset counts 8-byte blocks
    localparam word16_t FRAGMENT_OFFSET_UNIT = 16'd8;

    // Bit index inside the flags and offset word
    localparam int FLAG_MORE_FRAGMENTS = 13;

    ////////////////////////////////////////
    // UDP
    ////////////////////////////////////////

    localparam word16_t UDP_HEADER_BYTES = 16'd8;

    // MAC, IPv4 destination, ports and size on the input stream
    localparam int HEADER_STREAM_BYTES = 16;

endpackage

// ==== udp_transmit_handler.sv ====
module udp_transmit_handler #(
    parameter logic [15:0] max_fragment_bytes = 16'd1472
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      enable,
    input  logic [8:0]                data,
    input  logic                      data_enable,
    input  udp_proto_pkg::ipv4_addr_t ipv4_source,
    output logic                      data_ready,
    output udp_proto_pkg::mac_addr_t  mac_destination,
    output udp_proto_pkg::ipv4_addr_t ipv4_destination,
    output udp_proto_pkg::udp_port_t  udp_source,
    output udp_proto_pkg::udp_port_t  udp_destination,
    output udp_proto_pkg::word16_t    udp_total_payload_size,
    output udp_proto_pkg::word16_t    udp_buffer_write_address,
    output udp_proto_pkg::byte_t      udp_buffer_data,
    output logic                      udp_buffer_data_valid,
    output udp_proto_pkg::word16_t    udp_checksum,
    output udp_proto_pkg::word16_t    udp_fragment_size,
    output udp_proto_pkg::word16_t    ipv4_flags,
    output udp_proto_pkg::word16_t    ipv4_identification,
    output logic                      transmit_valid
);

    udp_proto_pkg::byte_t payload_byte;
    logic                 payload_valid;
    logic                 payload_last;
    logic                 checksum_done;
    logic                 frame_done;

    udp_header_if hdr_if ();

    // Captured header goes straight out
    assign mac_destination        = hdr_if.mac_destination;
    assign ipv4_destination       = hdr_if.ipv4_destination;
    assign udp_source             = hdr_if.udp_source;
    assign udp_destination        = hdr_if.udp_destination;
    assign udp_total_payload_size = hdr_if.payload_size;

    udp_header_decoder decoder_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .data          (data),
        .data_enable   (data_enable),
        .data_ready    (data_ready),
        .hdr           (hdr_if.decoder),
        .payload_byte  (payload_byte),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .frame_done    (frame_done)
    );

    udp_payload_checksum checksum_i (
        .clock                    (clock),
        .reset_n                  (reset_n),
        .ipv4_source              (ipv4_source),
        .hdr                      (hdr_if.consumer),
        .payload_byte             (payload_byte),
        .payload_valid            (payload_valid),
        .payload_last             (payload_last),
        .udp_buffer_write_address (udp_buffer_write_address),
        .udp_buffer_data          (udp_buffer_data),
        .udp_buffer_data_valid    (udp_buffer_data_valid),
        .udp_checksum             (udp_checksum),
        .checksum_done            (checksum_done)
    );

    udp_fragment_sequencer #(
        .max_fragment_bytes (max_fragment_bytes)
    ) sequencer_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .enable              (enable),
        .hdr                 (hdr_if.consumer),
        .checksum_done       (checksum_done),
        .udp_fragment_size   (udp_fragment_size),
        .ipv4_flags          (ipv4_flags),
        .ipv4_identification (ipv4_identification),
        .transmit_valid      (transmit_valid),
        .frame_done          (frame_done)
    );

endmodule

// ==== udp_tx_ctrl_pkg.sv ====
package udp_tx_ctrl_pkg;

    // Input side
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HEADER,
        RX_PAYLOAD,
        RX_BUSY
    } rx_state_e;

    // Transmit side, one pass through plan per fragment
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PLAN,
        TX_OFFER,
        TX_WAIT_BUSY,
        TX_WAIT_DONE
    } tx_state_e;

endpackage
